// ==== vlog.f ====
design/lin_pkg.sv
design/mem_if.sv
design/linear.sv
design/capture_writer.sv
design/mem_arbiter.sv
design/sample_ram.sv
design/lin_regs.sv
design/lin_capture_top.sv
verification/tb_lin_capture.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the sample capture block

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= tb_lin_capture
RTL_TOP   ?= lin_capture_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/tb_lin_capture.sv ====
// tb_lin_capture: clock, reset, wishbone and stream tasks, reference model, directed tests, watchdog
module tb_lin_capture import lin_pkg::*; ();

  localparam int N_SMP    = 106;                 // samples streamed over all tests
  localparam int WDOG_CYC = N_SMP * 20 + 2000;   // watchdog budget in clock cycles
  localparam int SMAX     = 2**(DWO-1) - 1;      // 8191
  localparam int SMIN     = -(2**(DWO-1));       // -8192

  logic                  clk, rstn;
  logic                  wb_cyc, wb_stb, wb_we, wb_ack;
  logic [7:0]            wb_adr;
  logic [31:0]           wb_dat_w, wb_dat_r;
  logic signed [DWI-1:0] ch0_dat, ch1_dat;
  logic                  ch0_vld, ch1_vld, ch0_rdy, ch1_rdy;

  int smp0 [64];
  int smp1 [64];  // stimulus per channel
  int exp0 [32];
  int exp1 [32];  // expected buffer words
  int n_err, n_pass, n_fail;
  int st0, st1;   // stall counts from the stream drivers

  lin_capture_top dut_i (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // reference, checks and reporting
  //////////////////////////////////////////////////

  // floor of (x * g) >>> 15, plus offset, clipped to 14 bits
  function automatic int cond_ref(input int smp, input int gain, input int offs);
    int v;
    v = (smp * gain) >>> 15;
    v = v + offs;
    if (v > SMAX) v = SMAX;
    else if (v < SMIN) v = SMIN;
    return v;
  endfunction

  task automatic check(input string name, input int got, input int want);
    if (got !== want) begin
      n_err++;
      $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, got, want);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    if (n_err == err_before) begin
      n_pass++;
      $display("test %s: ok", name);
    end else begin
      n_fail++;
      $display("test %s: %0d mismatches", name, n_err - err_before);
    end
  endtask

  //////////////////////////////////////////////////
  // bus and stream drivers
  //////////////////////////////////////////////////

  // all drivers start and end 2 units after a rising edge
  task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = dat;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);  // ack is registered, stable here
    @(posedge clk);
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);  // buffer reads wait on the arbiter
    dat = wb_dat_r;
    @(posedge clk);
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  function automatic bit chan_rdy(input int ch);
    return (ch == 0) ? ch0_rdy : ch1_rdy;
  endfunction

  // send smp[first..first+n-1], optional random idle gaps
  task automatic send_stream(input int ch, input int first, input int n, input int max_gap,
                             output int stalls);
    int s;
    stalls = 0;
    for (int i = first; i < first + n; i++) begin
      s = (ch == 0) ? smp0[i] : smp1[i];
      repeat ($urandom_range(max_gap, 0)) begin
        @(posedge clk);
        #2;
      end
      if (ch == 0) begin
        ch0_dat = DWI'(s);
        ch0_vld = 1'b1;
      end else begin
        ch1_dat = DWI'(s);
        ch1_vld = 1'b1;
      end
      @(negedge clk);
      while (!chan_rdy(ch)) begin  // held until the transfer edge
        stalls++;
        @(negedge clk);
      end
      @(posedge clk);
      #2;
      if (ch == 0) ch0_vld = 1'b0;
      else ch1_vld = 1'b0;
    end
  endtask

  // poll status until the masked bits match
  task automatic wait_status(input logic [31:0] mask, input logic [31:0] value);
    logic [31:0] d;
    wb_read(ADR_STAT, d);
    while ((d & mask) != value) wb_read(ADR_STAT, d);
  endtask

  task automatic check_buffer(input int ch, input int n);
    logic [31:0] d;
    for (int i = 0; i < n; i++) begin
      wb_read(ADR_BUF_BASE + 8'(32 * ch + i), d);
      check($sformatf("buf%0d[%0d]", ch, i), int'(d), (ch == 0) ? exp0[i] : exp1[i]);
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic reg_access();
    int e;
    logic [31:0] d;
    e = n_err;
    wb_read(ADR_STAT, d);
    check("stat after reset", int'(d), 0);
    wb_write(ADR_GAIN0, 32'h0000_1234);
    wb_write(ADR_OFFS0, 32'h0000_0567);
    wb_write(ADR_GAIN1, 32'h0000_7abc);
    wb_write(ADR_OFFS1, 32'h0000_1fff);
    wb_read(ADR_GAIN0, d);
    check("gain0", int'(d), 32'h1234);
    wb_read(ADR_OFFS0, d);
    check("offs0", int'(d), 32'h0567);
    wb_read(ADR_GAIN1, d);
    check("gain1", int'(d), 32'h7abc);
    wb_read(ADR_OFFS1, d);
    check("offs1", int'(d), 32'h1fff);
    report_test("register access", e);
  endtask

  task automatic unity_path();
    int e;
    logic [31:0] d;
    e = n_err;
    wb_write(ADR_GAIN0, 32767);
    wb_write(ADR_OFFS0, 0);
    for (int i = 0; i < 32; i++) begin
      smp0[i] = int'($urandom_range(16383, 0)) - 8192;
      exp0[i] = cond_ref(smp0[i], 32767, 0);
    end
    wb_write(ADR_CTRL, 32'h1);
    send_stream(0, 0, 32, 0, st0);
    wait_status(32'h1, 32'h1);  // done0
    wb_read(ADR_STAT, d);
    check("stat.fill0", int'(d[13:8]), REG_DEPTH);
    check_buffer(0, 32);
    report_test("unity path", e);
  endtask

  task automatic saturation();
    int e;
    int lim [3];
    e = n_err;
    lim = '{-8192, 0, 8191};
    wb_write(ADR_GAIN1, 32'h0000_8000);  // -32768
    wb_write(ADR_OFFS1, 8000);
    wb_write(ADR_CTRL, 32'h2);
    for (int i = 0; i < 6; i++) begin
      smp1[i] = lim[i % 3];
      exp1[i] = cond_ref(smp1[i], -32768, (i < 3) ? 8000 : -8000);
    end
    send_stream(1, 0, 3, 0, st1);
    wait_status(32'h003f_0000, 32'd3 << 16);  // first three stored before offset changes
    wb_write(ADR_OFFS1, -8000);
    send_stream(1, 3, 3, 0, st1);
    wait_status(32'h003f_0000, 32'd6 << 16);
    check_buffer(1, 6);
    report_test("saturation and offset", e);
  endtask

  task automatic concurrent_capture();
    int e;
    bit busy;
    logic [31:0] d;
    e = n_err;
    wb_write(ADR_GAIN0, 20000);
    wb_write(ADR_OFFS0, -100);
    wb_write(ADR_GAIN1, 32'h0000_cfc7);  // -12345
    wb_write(ADR_OFFS1, 300);
    for (int i = 0; i < 32; i++) begin
      smp0[i] = int'($urandom_range(16383, 0)) - 8192;
      smp1[i] = int'($urandom_range(16383, 0)) - 8192;
      exp0[i] = cond_ref(smp0[i], 20000, -100);
      exp1[i] = cond_ref(smp1[i], -12345, 300);
    end
    wb_write(ADR_CTRL, 32'h3);
    fork
      send_stream(0, 0, 32, 2, st0);
      send_stream(1, 0, 32, 2, st1);
      begin  // host polls status meanwhile
        busy = 1'b1;
        while (busy) begin
          wb_read(ADR_STAT, d);
          if (int'(d[13:8]) > REG_DEPTH) check("stat.fill0 bound", int'(d[13:8]), REG_DEPTH);
          if (int'(d[21:16]) > REG_DEPTH) check("stat.fill1 bound", int'(d[21:16]), REG_DEPTH);
          busy = (d[1:0] != 2'b11);
        end
      end
    join
    wb_read(ADR_STAT, d);
    check("stat.fill0", int'(d[13:8]), REG_DEPTH);
    check("stat.fill1", int'(d[21:16]), REG_DEPTH);
    check_buffer(0, 32);
    check_buffer(1, 32);
    report_test($sformatf("concurrent capture, stalls %0d/%0d", st0, st1), e);
  endtask

  task automatic done_discard();
    int e;
    logic [31:0] d;
    e = n_err;
    for (int i = 32; i < 36; i++) smp0[i] = int'($urandom_range(16383, 0)) - 8192;
    send_stream(0, 32, 4, 0, st0);
    check("ch0 stalls after done", st0, 0);
    repeat (6) @(posedge clk);  // let the pipeline drain
    #2;
    wb_read(ADR_STAT, d);
    check("stat.fill0 after discard", int'(d[13:8]), REG_DEPTH);
    check("stat.done0 after discard", int'(d[0]), 1);
    check_buffer(0, 32);
    wb_write(ADR_CTRL, 32'h1);  // re-arm channel 0 only
    wb_read(ADR_STAT, d);
    check("stat after re-arm", int'(d), (REG_DEPTH << 16) | 2);
    report_test("done and discard", e);
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hb011_0653));
    n_err    = 0;
    n_pass   = 0;
    n_fail   = 0;
    rstn     = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    ch0_dat  = '0;
    ch0_vld  = 1'b0;
    ch1_dat  = '0;
    ch1_vld  = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    rstn = 1'b1;
    reg_access();
    unity_path();
    saturation();
    concurrent_capture();
    done_discard();
    $display("tests passed %0d, failed %0d, mismatches %0d", n_pass, n_fail, n_err);
    if (n_fail == 0 && n_err == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(WDOG_CYC * 40);
    $display("timeout: simulation did not finish within %0d cycles", WDOG_CYC);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule : tb_lin_capture

// ==== design/lin_capture_top.sv ====
// module lin_capture_top: two conditioning channels, capture writers, regs, shared memory
module lin_capture_top import lin_pkg::*; (
  input  logic                  clk,
  input  logic                  rstn,
  // wishbone classic slave
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [7:0]            wb_adr,
  input  logic [31:0]           wb_dat_w,
  output logic [31:0]           wb_dat_r,
  output logic                  wb_ack,
  // sample streams
  input  logic signed [DWI-1:0] ch0_dat,
  input  logic                  ch0_vld,
  output logic                  ch0_rdy,
  input  logic signed [DWI-1:0] ch1_dat,
  input  logic                  ch1_vld,
  output logic                  ch1_rdy
);

  logic signed [DWO-1:0] lin0_dat, lin1_dat;  // conditioned streams
  logic                  lin0_vld, lin1_vld, lin0_rdy, lin1_rdy;
  logic signed [DWM-1:0] gain0, gain1;
  logic signed [DWS-1:0] offs0, offs1;
  logic                  arm0, arm1, done0, done1;
  logic [BUF_AW-1:0]     fill0, fill1;
  logic                  ram_we;
  logic [BUF_AW-1:0]     ram_addr;
  logic [DWO-1:0]        ram_wdat, ram_rdat;

  mem_if mem_bus [N_REQ] ();  // writer 0, writer 1, host

  //////////////////////////////////////////////////
  // channels
  //////////////////////////////////////////////////

  linear lin0_i (.clk, .rstn, .sti_dat(ch0_dat), .sti_vld(ch0_vld), .sti_rdy(ch0_rdy),
    .sto_dat(lin0_dat), .sto_vld(lin0_vld), .sto_rdy(lin0_rdy),
    .cfg_mul(gain0), .cfg_sum(offs0));
  linear lin1_i (.clk, .rstn, .sti_dat(ch1_dat), .sti_vld(ch1_vld), .sti_rdy(ch1_rdy),
    .sto_dat(lin1_dat), .sto_vld(lin1_vld), .sto_rdy(lin1_rdy),
    .cfg_mul(gain1), .cfg_sum(offs1));

  capture_writer cap0_i (.clk, .rstn, .sti_dat(lin0_dat), .sti_vld(lin0_vld),
    .sti_rdy(lin0_rdy), .arm(arm0), .region(1'b0), .done(done0), .fill(fill0),
    .mem(mem_bus[0]));  // words 0..31
  capture_writer cap1_i (.clk, .rstn, .sti_dat(lin1_dat), .sti_vld(lin1_vld),
    .sti_rdy(lin1_rdy), .arm(arm1), .region(1'b1), .done(done1), .fill(fill1),
    .mem(mem_bus[1]));  // words 32..63

  //////////////////////////////////////////////////
  // host side and memory
  //////////////////////////////////////////////////

  lin_regs regs_i (.clk, .rstn, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
    .wb_dat_r, .wb_ack, .done0, .done1, .fill0, .fill1,
    .gain0, .offs0, .gain1, .offs1, .arm0, .arm1, .mem(mem_bus[2]));

  mem_arbiter arb_i (.clk, .rstn, .req_port(mem_bus),
    .ram_we, .ram_addr, .ram_wdat, .ram_rdat);

  sample_ram ram_i (.clk, .we(ram_we), .addr(ram_addr), .wdat(ram_wdat), .rdat(ram_rdat));

endmodule : lin_capture_top

// ==== design/lin_regs.sv ====
// module lin_regs: wishbone slave, config and status registers, buffer read
module lin_regs import lin_pkg::*; (
  input  logic                  clk,
  input  logic                  rstn,
  // wishbone classic
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [7:0]            wb_adr,
  input  logic [31:0]           wb_dat_w,
  output logic [31:0]           wb_dat_r,
  output logic                  wb_ack,
  // status from writers
  input  logic                  done0,
  input  logic                  done1,
  input  logic [BUF_AW-1:0]     fill0,
  input  logic [BUF_AW-1:0]     fill1,
  // configuration
  output logic signed [DWM-1:0] gain0,
  output logic signed [DWS-1:0] offs0,
  output logic signed [DWM-1:0] gain1,
  output logic signed [DWS-1:0] offs1,
  output logic                  arm0,  // one-cycle pulses
  output logic                  arm1,
  // buffer read port
  mem_if.master                 mem
);

  logic start;   // new access seen
  logic buf_sel;
  logic rd_req;  // waiting for grant
  logic rd_dat;  // rdat arrives this cycle

  assign buf_sel = wb_adr[7] & ADR_BUF_BASE[7];
  assign start   = wb_cyc & wb_stb & ~wb_ack & ~rd_req & ~rd_dat;

  // host never writes the memory
  assign mem.req  = rd_req;
  assign mem.we   = 1'b0;
  assign mem.addr = wb_adr[BUF_AW-1:0];
  assign mem.wdat = '0;

  //////////////////////////////////////////////////
  // bus cycle control
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wb_ack <= 1'b0;
      rd_req <= 1'b0;
      rd_dat <= 1'b0;
    end else begin
      wb_ack <= 1'b0;                             // pulse
      if (start && buf_sel && !wb_we) rd_req <= 1'b1;
      else if (start) wb_ack <= 1'b1;             // registers, buffer writes
      if (rd_req && mem.gnt) begin
        rd_req <= 1'b0;
        rd_dat <= 1'b1;
      end
      if (rd_dat) begin
        rd_dat <= 1'b0;
        wb_ack <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // register writes and arm pulses
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      gain0 <= '0;
      offs0 <= '0;
      gain1 <= '0;
      offs1 <= '0;
      arm0  <= 1'b0;
      arm1  <= 1'b0;
    end else begin
      arm0 <= start && wb_we && wb_adr == ADR_CTRL && wb_dat_w[0];
      arm1 <= start && wb_we && wb_adr == ADR_CTRL && wb_dat_w[1];
      if (start && wb_we) begin
        case (wb_adr)  // buffer addresses match nothing here
          ADR_GAIN0: gain0 <= wb_dat_w[DWM-1:0];
          ADR_OFFS0: offs0 <= wb_dat_w[DWS-1:0];
          ADR_GAIN1: gain1 <= wb_dat_w[DWM-1:0];
          ADR_OFFS1: offs1 <= wb_dat_w[DWS-1:0];
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // read data
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rd_dat) wb_dat_r <= 32'($signed(mem.rdat));  // sign-extended sample
    else if (start && !wb_we) begin
      case (wb_adr)
        ADR_GAIN0: wb_dat_r <= 32'(gain0);
        ADR_OFFS0: wb_dat_r <= 32'(offs0);
        ADR_GAIN1: wb_dat_r <= 32'(gain1);
        ADR_OFFS1: wb_dat_r <= 32'(offs1);
        ADR_STAT:  wb_dat_r <= {10'b0, fill1, 2'b0, fill0, 6'b0, done1, done0};
        default:   wb_dat_r <= '0;  // ctrl reads as zero
      endcase
    end
  end

  a_ack_pulse : assert property (@(posedge clk) disable iff (!rstn) wb_ack |=> !wb_ack);

endmodule : lin_regs

// ==== design/sample_ram.sv ====
// module sample_ram: 64 x 14 single-port memory, registered read
module sample_ram import lin_pkg::*; (
  input  logic              clk,
  input  logic              we,
  input  logic [BUF_AW-1:0] addr,
  input  logic [DWO-1:0]    wdat,
  output logic [DWO-1:0]    rdat
);

  logic [DWO-1:0] mem_arr [2**BUF_AW];

  //////////////////////////////////////////////////
  // write and read port
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (we) mem_arr[addr] <= wdat;
  end

  // read first, data one cycle after the address
  always_ff @(posedge clk) begin
    rdat <= mem_arr[addr];
  end

endmodule : sample_ram

// ==== design/mem_arbiter.sv ====
// round-robin arbiter sharing one single-port sample memory among three requesters
module mem_arbiter import lin_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  mem_if.slave              req_port [N_REQ],
  // memory side
  output logic              ram_we,
  output logic [BUF_AW-1:0] ram_addr,
  output logic [DWO-1:0]    ram_wdat,
  input  logic [DWO-1:0]    ram_rdat
);

  logic [N_REQ-1:0]         req_v, we_v, gnt_v;
  logic [BUF_AW-1:0]        addr_a [N_REQ];
  logic [DWO-1:0]           wdat_a [N_REQ];
  logic [$clog2(N_REQ)-1:0] ptr, sel;  // search starts at ptr
  logic                     found;

  // flatten the interface array
  for (genvar i = 0; i < N_REQ; i++) begin : g_port
    assign req_v[i]         = req_port[i].req;
    assign we_v[i]          = req_port[i].we;
    assign addr_a[i]        = req_port[i].addr;
    assign wdat_a[i]        = req_port[i].wdat;
    assign req_port[i].gnt  = gnt_v[i];
    assign req_port[i].rdat = ram_rdat;  // same read data to all
  end

  //////////////////////////////////////////////////
  // selection starting at ptr
  //////////////////////////////////////////////////

  always_comb begin
    int idx;
    sel   = ptr;
    found = 1'b0;
    gnt_v = '0;
    for (int k = 0; k < N_REQ; k++) begin
      idx = int'(ptr) + k;
      if (idx >= N_REQ) idx = idx - N_REQ;  // wrap by hand, N_REQ is not a power of 2
      if (!found && req_v[idx]) begin
        sel   = idx[$clog2(N_REQ)-1:0];
        found = 1'b1;
      end
    end
    if (found) gnt_v[sel] = 1'b1;
  end

  assign ram_we   = found & we_v[sel];
  assign ram_addr = addr_a[sel];
  assign ram_wdat = wdat_a[sel];

  // next search starts after the winner
  always_ff @(posedge clk) begin
    if (!rstn)      ptr <= '0;
    else if (found) ptr <= (sel == N_REQ - 1) ? '0 : sel + 1'b1;
  end

  // a requester just served yields to any other still waiting
  for (genvar i = 0; i < N_REQ; i++) begin : g_fair
    a_rr_yield : assert property (@(posedge clk) disable iff (!rstn)
      gnt_v[i] && (req_v & ~gnt_v) != '0 |=> !gnt_v[i]);
  end

endmodule : mem_arbiter

// ==== design/capture_writer.sv ====
// module capture_writer: conditioned stream into one half of the sample memory
module capture_writer import lin_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  // conditioned stream
  input  logic [DWO-1:0]    sti_dat,
  input  logic              sti_vld,
  output logic              sti_rdy,
  // control and status
  input  logic              arm,     // one-cycle pulse from regs
  input  logic              region,  // which half of the memory
  output logic              done,
  output logic [BUF_AW-1:0] fill,    // samples stored since arm
  // memory port
  mem_if.master             mem
);

  logic armed;

  //////////////////////////////////////////////////
  // memory request
  //////////////////////////////////////////////////

  assign mem.req  = armed & sti_vld;
  assign mem.we   = 1'b1;  // write only
  assign mem.addr = {region, fill[BUF_AW-2:0]};
  assign mem.wdat = sti_dat;

  // idle or done: swallow samples so the channel never stalls
  assign sti_rdy = armed ? mem.gnt : 1'b1;

  //////////////////////////////////////////////////
  // fill counter and state
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      armed <= 1'b0;
      done  <= 1'b0;
      fill  <= '0;
    end else if (arm) begin  // arm wins over a same-cycle write
      armed <= 1'b1;
      done  <= 1'b0;
      fill  <= '0;
    end else if (armed && mem.gnt) begin
      fill <= fill + 1'b1;
      if (fill == BUF_AW'(REG_DEPTH - 1)) begin  // 32nd sample
        armed <= 1'b0;
        done  <= 1'b1;
      end
    end
  end

  a_fill_max : assert property (@(posedge clk) disable iff (!rstn)
    fill <= BUF_AW'(REG_DEPTH));

endmodule : capture_writer

// ==== design/linear.sv ====
// module linear: gain, offset and saturation pipeline on a valid/ready stream
module linear import lin_pkg::*; (
  input  logic                  clk,
  input  logic                  rstn,
  // input stream
  input  logic signed [DWI-1:0] sti_dat,
  input  logic                  sti_vld,
  output logic                  sti_rdy,
  // output stream
  output logic signed [DWO-1:0] sto_dat,
  output logic                  sto_vld,
  input  logic                  sto_rdy,
  // configuration
  input  logic signed [DWM-1:0] cfg_mul,  // gain, 32767 ~ unity
  input  logic signed [DWS-1:0] cfg_sum   // offset
);

  logic signed [DWI+DWM-1:0] mul_dat;  // full product
  logic signed [DWI:0]       shf_dat;  // product >>> (DWM-1)
  logic signed [DWI+1:0]     sum_dat;  // one guard bit over shf_dat
  logic signed [DWO-1:0]     sat_dat;
  logic                      sum_ovf;

  logic mul_vld, mul_rdy;
  logic sum_vld, sum_rdy;

  //////////////////////////////////////////////////
  // stage 1: multiply
  //////////////////////////////////////////////////

  assign sti_rdy = mul_rdy | ~mul_vld;  // empty or draining

  always_ff @(posedge clk) begin
    if (!rstn)        mul_vld <= 1'b0;
    else if (sti_rdy) mul_vld <= sti_vld;
  end

  always_ff @(posedge clk) begin
    if (sti_vld && sti_rdy) mul_dat <= sti_dat * cfg_mul;
  end

  //////////////////////////////////////////////////
  // stage 2: shift and add offset
  //////////////////////////////////////////////////

  // drop the low DWM-1 bits, arithmetic shift means floor
  assign shf_dat = mul_dat[DWI+DWM-1:DWM-1];

  assign mul_rdy = sum_rdy | ~sum_vld;

  always_ff @(posedge clk) begin
    if (!rstn)        sum_vld <= 1'b0;
    else if (mul_rdy) sum_vld <= mul_vld;
  end

  always_ff @(posedge clk) begin
    if (mul_vld && mul_rdy) sum_dat <= shf_dat + cfg_sum;
  end

  //////////////////////////////////////////////////
  // stage 3: saturate
  //////////////////////////////////////////////////

  // out of range unless the bits above the output sign all match it
  assign sum_ovf = ~(&sum_dat[DWI+1:DWO-1] | ~|sum_dat[DWI+1:DWO-1]);

  always_comb begin
    if (!sum_ovf)          sat_dat = sum_dat[DWO-1:0];
    else if (sum_dat[DWI+1]) sat_dat = {1'b1, {(DWO-1){1'b0}}};  // clip low
    else                   sat_dat = {1'b0, {(DWO-1){1'b1}}};  // clip high
  end

  assign sum_rdy = sto_rdy | ~sto_vld;

  always_ff @(posedge clk) begin
    if (!rstn)        sto_vld <= 1'b0;
    else if (sum_rdy) sto_vld <= sum_vld;
  end

  always_ff @(posedge clk) begin
    if (sum_vld && sum_rdy) sto_dat <= sat_dat;
  end

  // a stalled output word must not change under the sink
  a_sto_hold : assert property (@(posedge clk) disable iff (!rstn)
    sto_vld && !sto_rdy |=> sto_vld && $stable(sto_dat));

endmodule : linear

// ==== design/mem_if.sv ====
// interface mem_if: one requester's path to the shared sample memory
interface mem_if import lin_pkg::*; ();

  logic              req;   // held until gnt
  logic              we;    // 1 write, 0 read
  logic [BUF_AW-1:0] addr;
  logic [DWO-1:0]    wdat;
  logic              gnt;   // from arbiter, combinational
  logic [DWO-1:0]    rdat;  // valid the cycle after gnt

  // requester side
  modport master (
    output req, we, addr, wdat,
    input  gnt, rdat
  );

  // arbiter side
  modport slave (
    input  req, we, addr, wdat,
    output gnt, rdat
  );

endinterface : mem_if

// ==== design/lin_pkg.sv ====
// package lin_pkg: sample widths, sample memory geometry, register map
package lin_pkg;

  //////////////////////////////////////////////////
  // data widths
  //////////////////////////////////////////////////

  localparam int DWI = 14;  // input sample
  localparam int DWO = 14;  // conditioned sample, also memory word
  localparam int DWM = 16;  // gain, Q1.15
  localparam int DWS = 14;  // offset

  //////////////////////////////////////////////////
  // sample memory
  //////////////////////////////////////////////////

  localparam int BUF_AW    = 6;   // 64 words
  localparam int REG_DEPTH = 32;  // samples per channel, half the memory
  localparam int N_REQ     = 3;   // writer 0, writer 1, host

  //////////////////////////////////////////////////
  // register map, word addresses
  //////////////////////////////////////////////////

  localparam logic [7:0] ADR_GAIN0 = 8'd0;
  localparam logic [7:0] ADR_OFFS0 = 8'd1;
  localparam logic [7:0] ADR_GAIN1 = 8'd2;
  localparam logic [7:0] ADR_OFFS1 = 8'd3;
  localparam logic [7:0] ADR_CTRL  = 8'd4;  // write 1 to bit n arms channel n

  localparam logic [7:0] ADR_STAT  = 8'd5;  // done bits and fill counts

  // bit 7 selects the buffer window
  localparam logic [7:0] ADR_BUF_BASE = 8'd128;

endpackage : lin_pkg
